//--- csr_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared definitions for the machine-mode CSR file
// holds CSR numbers, field positions, op codes and the structs that
// travel between the access logic and the register blocks
//////////////////////////////////////////////////////////////////////

package csr_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned CSR_ADDR_W = 12;

  // single hart
  localparam logic [XLEN-1:0] HART_ID = 32'h0000_0000;

  // rv32 (MXL = 1) with the I and C extensions
  localparam logic [XLEN-1:0] MISA_VALUE = (32'(1) << 30)   // MXL
                                         | (32'(1) << 8)    // I
                                         | (32'(1) << 2);   // C

  //////////////////////////////////////////////////////////////////////
  // CSR numbers
  //////////////////////////////////////////////////////////////////////

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS       = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MISA          = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE           = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCOUNTINHIBIT = 12'h320;
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH      = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC          = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE        = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL         = 12'h343;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIP           = 12'h344;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE        = 12'hB00;
  localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET      = 12'hB02;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH       = 12'hB80;
  localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH     = 12'hB82;
  localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID       = 12'hF14;

  // mstatus fields
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LO   = 11;
  localparam int unsigned MSTATUS_MPP_HI   = 12;

  // mie / mip bits
  localparam int unsigned MSIX_BIT = 3;
  localparam int unsigned MTIX_BIT = 7;
  localparam int unsigned MEIX_BIT = 11;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // field view of a CSR number
  typedef struct packed {
    logic [1:0] access;  // 2'b11 marks a read-only CSR
    logic [1:0] priv;
    logic [7:0] idx;
  } csr_addr_fields_t;

  typedef union packed {
    logic [CSR_ADDR_W-1:0] raw;  // exact match against CSR numbers
    csr_addr_fields_t      f;
  } csr_addr_u;

  typedef struct packed {
    logic            valid;
    csr_addr_u       addr;
    csr_op_e         op;
    logic [XLEN-1:0] wdata;
  } csr_req_t;

  // resolved write, set and clear already folded in
  typedef struct packed {
    logic            we;
    csr_addr_u       addr;
    logic [XLEN-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic            save;   // trap entry
    logic            mret;
    logic [XLEN-1:0] pc;
    logic [5:0]      cause;  // {interrupt, code[4:0]}
    logic [XLEN-1:0] tval;
  } trap_ev_t;

  typedef struct packed {
    logic software;
    logic timer;
    logic external;
  } irq_t;

  typedef struct packed {
    logic       mie;
    logic       mpie;
    logic [1:0] mpp;
  } status_t;

endpackage

//--- csr_access.sv
//////////////////////////////////////////////////////////////////////
// CSR access path, purely combinational
// merges the block read data with misa and mhartid, flags illegal
// accesses and resolves WRITE/SET/CLEAR into one plain write
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_access (
  input  csr_pkg::csr_req_t         csr_req_i,
  input  logic [csr_pkg::XLEN-1:0]  trap_rdata_i,
  input  logic                      trap_hit_i,
  input  logic [csr_pkg::XLEN-1:0]  cnt_rdata_i,
  input  logic                      cnt_hit_i,
  output logic [csr_pkg::XLEN-1:0]  csr_rdata_o,
  output logic                      csr_illegal_o,
  output csr_pkg::csr_wr_t          csr_wr_o
);

  logic [csr_pkg::XLEN-1:0] const_rdata;
  logic                     const_hit;
  logic [csr_pkg::XLEN-1:0] rdata;
  logic [csr_pkg::XLEN-1:0] wdata;
  logic                     hit;
  logic                     is_write;
  logic                     ro_write;
  logic                     illegal;

  // constant CSRs live here, no storage behind them
  always_comb begin
    const_rdata = '0;
    const_hit   = 1'b1;
    unique case (csr_req_i.addr.raw)
      csr_pkg::CSR_MISA:    const_rdata = csr_pkg::MISA_VALUE;
      csr_pkg::CSR_MHARTID: const_rdata = csr_pkg::HART_ID;
      default:              const_hit   = 1'b0;
    endcase
  end

  // blocks return zero when they miss, so OR is enough
  assign rdata = trap_rdata_i | cnt_rdata_i | const_rdata;
  assign hit   = trap_hit_i | cnt_hit_i | const_hit;

  //////////////////////////////////////////////////////////////////////
  // legality
  //////////////////////////////////////////////////////////////////////

  assign is_write = (csr_req_i.op != csr_pkg::CSR_OP_READ);
  assign ro_write = is_write && (csr_req_i.addr.f.access == 2'b11);
  assign illegal  = csr_req_i.valid && (!hit || ro_write);

  assign csr_rdata_o   = csr_req_i.valid ? rdata : '0;
  assign csr_illegal_o = illegal;

  //////////////////////////////////////////////////////////////////////
  // write data
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (csr_req_i.op)
      csr_pkg::CSR_OP_WRITE: wdata = csr_req_i.wdata;
      csr_pkg::CSR_OP_SET:   wdata = rdata | csr_req_i.wdata;
      csr_pkg::CSR_OP_CLEAR: wdata = rdata & ~csr_req_i.wdata;
      default:               wdata = rdata;  // read, we stays low
    endcase
  end

  assign csr_wr_o.we   = csr_req_i.valid && is_write && !illegal;
  assign csr_wr_o.addr = csr_req_i.addr;
  assign csr_wr_o.data = wdata;

endmodule

//--- csr_trap_regs.sv
//////////////////////////////////////////////////////////////////////
// trap and interrupt CSRs
// mstatus, mie, mip, mscratch, mepc, mcause and mtval with their read
// decode, masked CSR writes, trap entry and mret
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_trap_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  csr_pkg::csr_addr_u        addr_i,
  input  csr_pkg::csr_wr_t          csr_wr_i,
  input  csr_pkg::trap_ev_t         trap_i,
  input  csr_pkg::irq_t             irq_i,
  output logic [csr_pkg::XLEN-1:0]  rdata_o,
  output logic                      hit_o,
  output logic                      irq_pending_o,
  output logic                      mie_o,
  output logic [csr_pkg::XLEN-1:0]  mepc_o
);

  csr_pkg::status_t         mstatus_q, mstatus_d;
  csr_pkg::irq_t            mie_q, mie_d;
  csr_pkg::irq_t            mip;
  logic [csr_pkg::XLEN-1:0] mscratch_q, mscratch_d;
  logic [csr_pkg::XLEN-1:0] mepc_q, mepc_d;
  logic [5:0]               mcause_q, mcause_d;
  logic [csr_pkg::XLEN-1:0] mtval_q, mtval_d;

  // place the three irq bits at their mie/mip positions
  function automatic logic [csr_pkg::XLEN-1:0] irq_word(csr_pkg::irq_t v);
    logic [csr_pkg::XLEN-1:0] w;
    w                    = '0;
    w[csr_pkg::MSIX_BIT] = v.software;
    w[csr_pkg::MTIX_BIT] = v.timer;
    w[csr_pkg::MEIX_BIT] = v.external;
    return w;
  endfunction

  assign mip           = irq_i & mie_q;  // no latching, follows the lines
  assign irq_pending_o = |mip;

  //////////////////////////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    unique case (addr_i.raw)
      csr_pkg::CSR_MSTATUS: begin
        rdata_o[csr_pkg::MSTATUS_MIE_BIT]                        = mstatus_q.mie;
        rdata_o[csr_pkg::MSTATUS_MPIE_BIT]                       = mstatus_q.mpie;
        rdata_o[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = mstatus_q.mpp;
      end
      csr_pkg::CSR_MIE:      rdata_o = irq_word(mie_q);
      csr_pkg::CSR_MIP:      rdata_o = irq_word(mip);
      csr_pkg::CSR_MSCRATCH: rdata_o = mscratch_q;
      csr_pkg::CSR_MEPC:     rdata_o = mepc_q;
      csr_pkg::CSR_MCAUSE:   rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      csr_pkg::CSR_MTVAL:    rdata_o = mtval_q;
      default:               hit_o   = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // next state, CSR write first and trap event on top
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;

    if (csr_wr_i.we) begin
      unique case (csr_wr_i.addr.raw)
        csr_pkg::CSR_MSTATUS: begin
          mstatus_d.mie  = csr_wr_i.data[csr_pkg::MSTATUS_MIE_BIT];
          mstatus_d.mpie = csr_wr_i.data[csr_pkg::MSTATUS_MPIE_BIT];
          mstatus_d.mpp  = 2'b11;  // M-mode only
        end
        csr_pkg::CSR_MIE: begin
          mie_d.software = csr_wr_i.data[csr_pkg::MSIX_BIT];
          mie_d.timer    = csr_wr_i.data[csr_pkg::MTIX_BIT];
          mie_d.external = csr_wr_i.data[csr_pkg::MEIX_BIT];
        end
        csr_pkg::CSR_MSCRATCH: mscratch_d = csr_wr_i.data;
        csr_pkg::CSR_MEPC:     mepc_d     = {csr_wr_i.data[31:1], 1'b0};
        csr_pkg::CSR_MCAUSE:   mcause_d   = {csr_wr_i.data[31], csr_wr_i.data[4:0]};
        csr_pkg::CSR_MTVAL:    mtval_d    = csr_wr_i.data;
        default: ;  // mip and the rest ignore writes
      endcase
    end

    // trap event wins over a write in the same cycle
    if (trap_i.save) begin
      mepc_d         = {trap_i.pc[31:1], 1'b0};  // keeps mepc[0] at 0
      mcause_d       = trap_i.cause;
      mtval_d        = trap_i.tval;
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
    end else if (trap_i.mret) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_q  <= '{mie: 1'b0, mpie: 1'b0, mpp: 2'b11};
      mie_q      <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else begin
      mstatus_q  <= mstatus_d;
      mie_q      <= mie_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
    end
  end

  assign mie_o  = mstatus_q.mie;
  assign mepc_o = mepc_q;

endmodule

//--- csr_counters.sv
//////////////////////////////////////////////////////////////////////
// mcycle and minstret 64-bit counters with mcountinhibit
// an enabled event increments first, a CSR write to either half then
// replaces that half of the incremented value
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_counters (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  csr_pkg::csr_addr_u        addr_i,
  input  csr_pkg::csr_wr_t          csr_wr_i,
  input  logic                      instr_ret_i,
  output logic [csr_pkg::XLEN-1:0]  rdata_o,
  output logic                      hit_o
);

  // index 0 is mcycle, index 1 is minstret
  logic [63:0] cnt_q [2];
  logic [63:0] cnt_d [2];
  logic [1:0]  inhibit_q, inhibit_d;  // mcountinhibit bits 0 and 2
  logic [1:0]  cnt_event;
  logic [1:0]  wr_lo;
  logic [1:0]  wr_hi;

  assign cnt_event = {instr_ret_i, 1'b1};  // mcycle counts every clock

  //////////////////////////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    unique case (addr_i.raw)
      csr_pkg::CSR_MCOUNTINHIBIT: begin
        rdata_o[0] = inhibit_q[0];
        rdata_o[2] = inhibit_q[1];  // bit 1 (time) reads 0
      end
      csr_pkg::CSR_MCYCLE:    rdata_o = cnt_q[0][31:0];
      csr_pkg::CSR_MCYCLEH:   rdata_o = cnt_q[0][63:32];
      csr_pkg::CSR_MINSTRET:  rdata_o = cnt_q[1][31:0];
      csr_pkg::CSR_MINSTRETH: rdata_o = cnt_q[1][63:32];
      default:                hit_o   = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // write decode and update
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    inhibit_d = inhibit_q;
    wr_lo     = '0;
    wr_hi     = '0;
    if (csr_wr_i.we) begin
      unique case (csr_wr_i.addr.raw)
        csr_pkg::CSR_MCOUNTINHIBIT: inhibit_d = {csr_wr_i.data[2], csr_wr_i.data[0]};
        csr_pkg::CSR_MCYCLE:        wr_lo[0]  = 1'b1;
        csr_pkg::CSR_MCYCLEH:       wr_hi[0]  = 1'b1;
        csr_pkg::CSR_MINSTRET:      wr_lo[1]  = 1'b1;
        csr_pkg::CSR_MINSTRETH:     wr_hi[1]  = 1'b1;
        default: ;
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      cnt_d[i] = cnt_q[i];
      if (cnt_event[i] && !inhibit_q[i]) begin
        cnt_d[i] = cnt_q[i] + 64'd1;
      end
      if (wr_lo[i]) begin
        cnt_d[i][31:0] = csr_wr_i.data;
      end
      if (wr_hi[i]) begin
        cnt_d[i][63:32] = csr_wr_i.data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
      for (int i = 0; i < 2; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      inhibit_q <= inhibit_d;
      for (int i = 0; i < 2; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

endmodule

//--- csr_top.sv
//////////////////////////////////////////////////////////////////////
// machine-mode CSR file top level
// single-cycle request in, read data and illegal flag back in the same
// cycle, writes and trap effects visible one clock later
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module csr_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  csr_pkg::csr_req_t         csr_req_i,
  output logic [csr_pkg::XLEN-1:0]  csr_rdata_o,
  output logic                      csr_illegal_o,
  input  csr_pkg::trap_ev_t         trap_i,
  input  csr_pkg::irq_t             irq_i,
  input  logic                      instr_ret_i,
  output logic                      irq_pending_o,
  output logic                      csr_mie_o,
  output logic [csr_pkg::XLEN-1:0]  csr_mepc_o
);

  logic [csr_pkg::XLEN-1:0] trap_rdata;
  logic                     trap_hit;
  logic [csr_pkg::XLEN-1:0] cnt_rdata;
  logic                     cnt_hit;
  csr_pkg::csr_wr_t         csr_wr;  // resolved write back to both blocks

  csr_access u_access (
    .csr_req_i     (csr_req_i),
    .trap_rdata_i  (trap_rdata),
    .trap_hit_i    (trap_hit),
    .cnt_rdata_i   (cnt_rdata),
    .cnt_hit_i     (cnt_hit),
    .csr_rdata_o   (csr_rdata_o),
    .csr_illegal_o (csr_illegal_o),
    .csr_wr_o      (csr_wr)
  );

  csr_trap_regs u_trap_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .addr_i        (csr_req_i.addr),
    .csr_wr_i      (csr_wr),
    .trap_i        (trap_i),
    .irq_i         (irq_i),
    .rdata_o       (trap_rdata),
    .hit_o         (trap_hit),
    .irq_pending_o (irq_pending_o),
    .mie_o         (csr_mie_o),
    .mepc_o        (csr_mepc_o)
  );

  csr_counters u_counters (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .addr_i      (csr_req_i.addr),
    .csr_wr_i    (csr_wr),
    .instr_ret_i (instr_ret_i),
    .rdata_o     (cnt_rdata),
    .hit_o       (cnt_hit)
  );

endmodule

//--- tb_csr_asserts.sv
//////////////////////////////////////////////////////////////////////
// concurrent checks on the CSR file, bound onto csr_top
// illegal flag only with a request, mie cleared after a trap save and
// irq_pending_o against a read of mip
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_csr_asserts (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        valid_i,
  input logic [11:0] addr_i,
  input logic        illegal_i,
  input logic [31:0] rdata_i,
  input logic        save_i,
  input logic        mie_i,
  input logic        irq_pending_i
);

  int fail_count = 0;

  a_illegal_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !valid_i |-> !illegal_i
  ) else begin
    $error("csr_illegal_o high without a valid request");
    fail_count++;
  end

  a_mie_cleared_on_trap: assert property (
    @(posedge clk_i) disable iff (!rst_ni) save_i |=> !mie_i
  ) else begin
    $error("mstatus.mie still set one cycle after trap entry");
    fail_count++;
  end

  // mip as seen on the read path
  a_pending_is_mip: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (valid_i && addr_i == csr_pkg::CSR_MIP) |-> (irq_pending_i == (|rdata_i))
  ) else begin
    $error("irq_pending_o differs from the OR of mip");
    fail_count++;
  end

endmodule

//--- tb_csr_checker.sv
//////////////////////////////////////////////////////////////////////
// reference model of the machine-mode CSRs for the testbench
// compares the DUT outputs every cycle at the falling edge, then steps
// the model; prints one line per test and the totals at the end
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_csr_checker (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  csr_pkg::csr_req_t    csr_req_i,
  input  logic [31:0]          csr_rdata_i,
  input  logic                 csr_illegal_i,
  input  csr_pkg::trap_ev_t    trap_i,
  input  csr_pkg::irq_t        irq_i,
  input  logic                 instr_ret_i,
  input  logic                 irq_pending_i,
  input  logic                 csr_mie_i,
  input  logic [31:0]          csr_mepc_i,
  input  int                   test_id_i,
  input  logic                 done_i,
  output int                   errors_o
);

  logic        m_st_mie, m_st_mpie;
  logic [31:0] m_mie, m_scratch, m_epc, m_cause, m_tval;
  logic [63:0] m_cyc, m_ins;
  logic [1:0]  m_inh;  // {minstret, mcycle}
  int          checks, test_checks, test_errors, cur_test;
  logic        finished;

  initial begin
    errors_o = 0;
    checks   = 0;
    cur_test = 0;
    finished = 1'b0;
  end

  // {hit, value} for one CSR number
  function automatic logic [32:0] model_read(logic [11:0] a, logic [31:0] mip);
    case (a)
      csr_pkg::CSR_MSTATUS:
        return {1'b1, 19'b0, 2'b11, 3'b0, m_st_mpie, 3'b0, m_st_mie, 3'b0};
      csr_pkg::CSR_MISA:          return {1'b1, 32'h4000_0104};  // MXL=1, I, C
      csr_pkg::CSR_MHARTID:       return {1'b1, csr_pkg::HART_ID};
      csr_pkg::CSR_MIE:           return {1'b1, m_mie};
      csr_pkg::CSR_MIP:           return {1'b1, mip};
      csr_pkg::CSR_MSCRATCH:      return {1'b1, m_scratch};
      csr_pkg::CSR_MEPC:          return {1'b1, m_epc};
      csr_pkg::CSR_MCAUSE:        return {1'b1, m_cause};
      csr_pkg::CSR_MTVAL:         return {1'b1, m_tval};
      csr_pkg::CSR_MCOUNTINHIBIT: return {1'b1, 29'b0, m_inh[1], 1'b0, m_inh[0]};
      csr_pkg::CSR_MCYCLE:        return {1'b1, m_cyc[31:0]};
      csr_pkg::CSR_MCYCLEH:       return {1'b1, m_cyc[63:32]};
      csr_pkg::CSR_MINSTRET:      return {1'b1, m_ins[31:0]};
      csr_pkg::CSR_MINSTRETH:     return {1'b1, m_ins[63:32]};
      default:                    return '0;
    endcase
  endfunction

  task automatic model_write(logic [11:0] a, logic [31:0] d);
    case (a)
      csr_pkg::CSR_MSTATUS: begin
        m_st_mie  = d[3];
        m_st_mpie = d[7];
      end
      csr_pkg::CSR_MIE:           m_mie     = d & 32'h0000_0888;
      csr_pkg::CSR_MSCRATCH:      m_scratch = d;
      csr_pkg::CSR_MEPC:          m_epc     = d & ~32'h1;
      csr_pkg::CSR_MCAUSE:        m_cause   = d & 32'h8000_001F;
      csr_pkg::CSR_MTVAL:         m_tval    = d;
      csr_pkg::CSR_MCOUNTINHIBIT: m_inh     = {d[2], d[0]};
      csr_pkg::CSR_MCYCLE:        m_cyc[31:0]  = d;
      csr_pkg::CSR_MCYCLEH:       m_cyc[63:32] = d;
      csr_pkg::CSR_MINSTRET:      m_ins[31:0]  = d;
      csr_pkg::CSR_MINSTRETH:     m_ins[63:32] = d;
      default: ;  // misa, mhartid and mip keep their value
    endcase
  endtask

  task automatic check(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors_o++;
      test_errors++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test();
    $display("test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare, then advance the model by one clock
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : model_step
    logic [31:0] irq_w, mip, wdata;
    logic [32:0] rd;
    logic        is_wr, exp_ill, old_mie, old_mpie;

    if (!rst_ni) begin
      {m_st_mie, m_st_mpie, m_inh} = '0;
      {m_mie, m_scratch, m_epc, m_cause, m_tval} = '0;
      m_cyc = '0;
      m_ins = '0;
    end else if (done_i) begin
      if (!finished) begin
        report_test();
        $display("all tests: %0d checks, %0d errors", checks, errors_o);
        finished = 1'b1;
      end
    end else begin
      if (test_id_i != cur_test) begin
        if (cur_test != 0) report_test();
        cur_test    = test_id_i;
        test_checks = 0;
        test_errors = 0;
      end
      irq_w   = {20'b0, irq_i.external, 3'b0, irq_i.timer, 3'b0, irq_i.software, 3'b0};
      mip     = irq_w & m_mie;
      rd      = model_read(csr_req_i.addr.raw, mip);
      is_wr   = (csr_req_i.op != csr_pkg::CSR_OP_READ);
      exp_ill = csr_req_i.valid && (!rd[32] || (is_wr && csr_req_i.addr.raw[11:10] == 2'b11));

      check("csr_rdata_o", csr_rdata_i, csr_req_i.valid ? rd[31:0] : 32'b0);
      check("csr_illegal_o", {31'b0, csr_illegal_i}, {31'b0, exp_ill});
      check("irq_pending_o", {31'b0, irq_pending_i}, {31'b0, |mip});
      check("csr_mie_o", {31'b0, csr_mie_i}, {31'b0, m_st_mie});
      check("csr_mepc_o", csr_mepc_i, m_epc);

      old_mie  = m_st_mie;
      old_mpie = m_st_mpie;
      if (!m_inh[0]) m_cyc = m_cyc + 64'd1;
      if (instr_ret_i && !m_inh[1]) m_ins = m_ins + 64'd1;

      case (csr_req_i.op)
        csr_pkg::CSR_OP_SET:   wdata = rd[31:0] | csr_req_i.wdata;
        csr_pkg::CSR_OP_CLEAR: wdata = rd[31:0] & ~csr_req_i.wdata;
        default:               wdata = csr_req_i.wdata;
      endcase
      if (csr_req_i.valid && is_wr && !exp_ill) model_write(csr_req_i.addr.raw, wdata);

      // trap event overrides any write of the same cycle
      if (trap_i.save) begin
        m_epc     = trap_i.pc & ~32'h1;
        m_cause   = {trap_i.cause[5], 26'b0, trap_i.cause[4:0]};
        m_tval    = trap_i.tval;
        m_st_mpie = old_mie;
        m_st_mie  = 1'b0;
      end else if (trap_i.mret) begin
        m_st_mie  = old_mpie;
        m_st_mpie = 1'b1;
      end
    end
  end

endmodule

//--- tb_csr_top.sv
//////////////////////////////////////////////////////////////////////
// testbench top for the CSR file
// five random tests of fixed length driven from a Galois LFSR,
// checked by tb_csr_checker, with a cycle limit against hangs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_csr_top;

  localparam int RESET_CYCLES   = 5;
  localparam int NUM_TESTS      = 5;
  localparam int TEST_CYCLES    = 400;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES + 100;

  logic              clk_i, rst_ni, instr_ret, irq_pending, csr_mie, csr_illegal, done;
  logic [31:0]       csr_rdata, csr_mepc;
  csr_pkg::csr_req_t csr_req;
  csr_pkg::trap_ev_t trap;
  csr_pkg::irq_t     irq;
  logic [15:0]       lfsr;
  int                test_id, cycles, errors;

  csr_top csr_top_i (
    .clk_i, .rst_ni,
    .csr_req_i (csr_req), .csr_rdata_o (csr_rdata), .csr_illegal_o (csr_illegal),
    .trap_i (trap), .irq_i (irq), .instr_ret_i (instr_ret),
    .irq_pending_o (irq_pending), .csr_mie_o (csr_mie), .csr_mepc_o (csr_mepc)
  );

  tb_csr_checker u_checker (
    .clk_i, .rst_ni,
    .csr_req_i (csr_req), .csr_rdata_i (csr_rdata), .csr_illegal_i (csr_illegal),
    .trap_i (trap), .irq_i (irq), .instr_ret_i (instr_ret),
    .irq_pending_i (irq_pending), .csr_mie_i (csr_mie), .csr_mepc_i (csr_mepc),
    .test_id_i (test_id), .done_i (done), .errors_o (errors)
  );

  bind csr_top tb_csr_asserts u_asserts (
    .clk_i, .rst_ni,
    .valid_i (csr_req_i.valid), .addr_i (csr_req_i.addr.raw),
    .illegal_i (csr_illegal_o), .rdata_i (csr_rdata_o), .save_i (trap_i.save),
    .mie_i (csr_mie_o), .irq_pending_i (irq_pending_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [11:0] csr_at(logic [31:0] i);
    case (i)
      0:       return csr_pkg::CSR_MSCRATCH;
      1:       return csr_pkg::CSR_MEPC;
      2:       return csr_pkg::CSR_MTVAL;
      3:       return csr_pkg::CSR_MSTATUS;
      4:       return csr_pkg::CSR_MIE;
      5:       return csr_pkg::CSR_MCAUSE;
      6:       return csr_pkg::CSR_MIP;
      7:       return csr_pkg::CSR_MCOUNTINHIBIT;
      8:       return csr_pkg::CSR_MCYCLE;
      9:       return csr_pkg::CSR_MCYCLEH;
      10:      return csr_pkg::CSR_MINSTRET;
      11:      return csr_pkg::CSR_MINSTRETH;
      12:      return csr_pkg::CSR_MISA;
      default: return csr_pkg::CSR_MHARTID;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // one cycle of random stimulus for test t
  //////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(int t);
    logic [31:0]       r, sel, off, mix;
    logic [11:0]       a;
    csr_pkg::csr_req_t req;
    csr_pkg::trap_ev_t tr;
    r         = rand_bits(2);
    req.valid = (r[1:0] != 2'b00);  // three requests in four cycles
    sel       = rand_bits(5);
    off       = (sel % 29) + 3;      // hpm index 3..31
    case (t)
      1:       a = csr_at(sel % 3);        // mscratch, mepc, mtval
      2:       a = csr_at(3 + sel % 4);    // mstatus, mie, mcause, mip
      3:       a = csr_at(1 + sel % 5);
      4:       a = csr_at(7 + sel % 5);    // counters and mcountinhibit
      default: begin
        r = rand_bits(3);
        case (r[1:0])
          2'd0: begin
            mix = rand_bits(12);
            a   = sel[11:0] ^ mix[11:0];
          end
          2'd1:    a = (r[2] ? 12'hB80 : 12'hB00) + off[11:0];
          2'd2:    a = 12'h320 + off[11:0];  // event selectors
          default: a = csr_at(sel % 14);
        endcase
      end
    endcase
    req.addr.raw = a;
    r            = rand_bits(2);
    req.op       = csr_pkg::csr_op_e'(r[1:0]);
    req.wdata    = rand_bits(32);
    tr           = '0;
    if (t == 3) begin
      r        = rand_bits(3);
      tr.save  = (r[2:0] == 3'd0);
      r        = rand_bits(3);
      tr.mret  = (r[2:0] == 3'd0);
      tr.pc    = rand_bits(32);
      tr.tval  = rand_bits(32);
      r        = rand_bits(6);
      tr.cause = r[5:0];
    end
    csr_req   <= req;
    trap      <= tr;
    r          = rand_bits(4);
    irq       <= csr_pkg::irq_t'(r[2:0]);
    instr_ret <= r[3];
    test_id   <= t;
  endtask

  initial begin
    lfsr      = 16'd57661;
    rst_ni    = 1'b0;
    csr_req   = '0;
    trap      = '0;
    irq       = '0;
    instr_ret = 1'b0;
    test_id   = 0;
    done      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      repeat (TEST_CYCLES) begin
        @(posedge clk_i);
        drive_cycle(t);
      end
    end
    @(posedge clk_i);
    csr_req   <= '0;
    trap      <= '0;
    instr_ret <= 1'b0;
    done      <= 1'b1;
    repeat (2) @(posedge clk_i);  // let the checker print its totals
    if (errors != 0 || csr_top_i.u_asserts.fail_count != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

  initial cycles = 0;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

//--- all.f
csr_pkg.sv
csr_access.sv
csr_trap_regs.sv
csr_counters.sv
csr_top.sv
tb_csr_asserts.sv
tb_csr_checker.sv
tb_csr_top.sv

//--- Makefile
TOP = tb_csr_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f all.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
